// File: logic/img_timing_pkg.sv
package img_timing_pkg;

    // frame geometry
    // pixels per line
    localparam int img_width = 16;
    // lines per frame
    localparam int img_height = 8;

    // every blanking gap has the same length
    localparam int gap_cycles = 16;

    // timer must hold the longest interval it is loaded with
    localparam int timer_max = (img_width > gap_cycles) ? img_width : gap_cycles;
    localparam int timer_w = $clog2(timer_max + 1);

    // column and row counters wrap on their own at the frame edges
    localparam int col_w = $clog2(img_width);
    localparam int row_w = $clog2(img_height);

    // timer load values, sized to the timer port
    localparam logic [timer_w-1:0] gap_load = timer_w'(gap_cycles);
    localparam logic [timer_w-1:0] line_load = timer_w'(img_width);

    // last column and last row indices
    localparam logic [col_w-1:0] last_col = col_w'(img_width - 1);
    localparam logic [row_w-1:0] last_row = row_w'(img_height - 1);

    // sequencer states
    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        // fv low ahead of the frame
        st_frame_blank = 3'd1,
        // fv high, no line yet
        st_frame_lead  = 3'd2,
        st_line_active = 3'd3,
        st_line_gap    = 3'd4,
        // fv low after the last line
        st_frame_trail = 3'd5
    } seq_state_t;

endpackage

// File: logic/img_data_pkg.sv
package img_data_pkg;

    // sensor pixel width
    localparam int pix_w = 12;

    // capture fifo sizing
    localparam int fifo_depth = 32;
    localparam int fifo_aw = $clog2(fifo_depth);
    // stored word is {sof, eol, pixel}
    localparam int fifo_entry_w = pix_w + 2;

    // completed frame counter
    localparam int frame_cnt_w = 8;

    // row/col pattern packs each index into half a pixel
    localparam int code_w = pix_w / 2;

    // grid highlight value
    localparam logic [pix_w-1:0] grid_on = '1;

    // test pattern select
    typedef enum logic [1:0] {
        // running pixel count per frame
        pat_ramp   = 2'd0,
        // bright dot every 4th row and column
        pat_grid   = 2'd1,
        // row in the upper half, column in the lower half
        pat_rowcol = 2'd2
    } pattern_t;

endpackage

// File: logic/img_bus_if.sv
`timescale 1ns/1ps

interface img_bus_if ();
    import img_data_pkg::*;

    // frame valid and line valid
    logic fv;
    logic lv;
    // pixel value, only meaningful while lv is high
    logic [pix_w-1:0] d;
    // high through the last line of a frame
    logic row_last;

    // sequencer drives the valids and watches for the last row
    modport seq (output fv, output lv, input row_last);

    // generator follows the valids and supplies pixels
    modport gen (input fv, input lv, output d, output row_last);

    // capture side only listens
    modport cap (input fv, input lv, input d, input row_last);

endinterface

// File: logic/img_seq_fsm.sv
`timescale 1ns/1ps

module img_seq_fsm (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               enable,
    img_bus_if.seq                             bus,
    output logic                               load,
    output logic [img_timing_pkg::timer_w-1:0] load_value,
    input  logic                               done
);
    import img_timing_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    // row_last sampled at the end of each active line
    logic last_line;

    // next state plus timer load on every state entry
    always_comb begin
        state_nxt = state;
        load = 1'b0;
        load_value = '0;
        case (state)
            st_idle: begin
                // enable only looked at here and at end of trail
                if (enable) begin
                    state_nxt = st_frame_blank;
                    load = 1'b1;
                    load_value = gap_load;
                end
            end
            st_frame_blank: begin
                if (done) begin
                    state_nxt = st_frame_lead;
                    load = 1'b1;
                    load_value = gap_load;
                end
            end
            st_frame_lead: begin
                if (done) begin
                    state_nxt = st_line_active;
                    load = 1'b1;
                    load_value = line_load;
                end
            end
            st_line_active: begin
                if (done) begin
                    state_nxt = st_line_gap;
                    load = 1'b1;
                    load_value = gap_load;
                end
            end
            st_line_gap: begin
                if (done) begin
                    load = 1'b1;
                    // leave the line loop after the gap of the final row
                    if (last_line) begin
                        state_nxt = st_frame_trail;
                        load_value = gap_load;
                    end else begin
                        state_nxt = st_line_active;
                        load_value = line_load;
                    end
                end
            end
            st_frame_trail: begin
                if (done) begin
                    // back to back frames while enable stays high
                    if (enable) begin
                        state_nxt = st_frame_blank;
                        load = 1'b1;
                        load_value = gap_load;
                    end else begin
                        state_nxt = st_idle;
                    end
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            last_line <= 1'b0;
        end else begin
            state <= state_nxt;
            // generator row moves on once lv drops, so grab it now
            if (state == st_line_active && done) begin
                last_line <= bus.row_last;
            end
        end
    end

    // valids decoded straight from the state register
    assign bus.fv = (state == st_frame_lead) || (state == st_line_active) ||
                    (state == st_line_gap);
    assign bus.lv = (state == st_line_active);

endmodule

// File: logic/img_gap_timer.sv
`timescale 1ns/1ps

module img_gap_timer (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load,
    input  logic [img_timing_pkg::timer_w-1:0] load_value,
    output logic                               done
);
    import img_timing_pkg::*;

    // cycles left in the current interval, zero when idle
    logic [timer_w-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            // a load wins over the countdown
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // fires in the last cycle of the interval
    // the fsm reloads in that same cycle so the pulse stays one wide
    // stuck at zero gives no pulse while idle
    assign done = (count == timer_w'(1));

endmodule

// File: logic/img_pixel_gen.sv
`timescale 1ns/1ps

module img_pixel_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  img_data_pkg::pattern_t pattern,
    img_bus_if.gen                 bus
);
    import img_timing_pkg::*;
    import img_data_pkg::*;

    // delayed valids for edge detection
    logic fv_q;
    logic lv_q;
    logic [col_w-1:0] col_q;
    logic [row_w-1:0] row_q;
    // per frame pixel ramp
    logic [pix_w-1:0] ramp_q;
    // pattern held for the whole frame
    pattern_t pattern_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
            col_q <= '0;
            row_q <= '0;
            ramp_q <= '0;
            pattern_q <= pat_ramp;
        end else begin
            fv_q <= bus.fv;
            lv_q <= bus.lv;
            if (bus.fv && !fv_q) begin
                // frame start restarts everything and takes the new pattern
                col_q <= '0;
                row_q <= '0;
                ramp_q <= '0;
                pattern_q <= pattern;
            end else if (bus.lv) begin
                col_q <= col_q + 1'b1;
                ramp_q <= ramp_q + 1'b1;
            end else if (lv_q) begin
                // lv just fell so move to the next row
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end
        end
    end

    // pixel value from the current position
    always_comb begin
        case (pattern_q)
            pat_ramp:   bus.d = ramp_q;
            pat_grid:   bus.d = (row_q[1:0] == 2'b00 && col_q[1:0] == 2'b00) ? grid_on : '0;
            pat_rowcol: bus.d = {code_w'(row_q), code_w'(col_q)};
            default:    bus.d = '0;
        endcase
    end

    // row counter wraps after the final line, so this drops in its gap
    assign bus.row_last = (row_q == last_row);

endmodule

// File: logic/img_capture.sv
`timescale 1ns/1ps

module img_capture (
    input  logic                                   clk,
    input  logic                                   reset,
    img_bus_if.cap                                 bus,
    output logic [img_data_pkg::pix_w-1:0]         pix_data,
    output logic                                   pix_sof,
    output logic                                   pix_eol,
    output logic                                   pix_valid,
    input  logic                                   pix_ready,
    output logic                                   overflow,
    output logic [img_data_pkg::frame_cnt_w-1:0]   frame_count
);
    import img_timing_pkg::*;
    import img_data_pkg::*;

    // previous fv for edge detection
    logic fv_q;
    // armed at frame start, consumed by the first pixel
    logic sof_pend;
    // own column count for eol tagging
    logic [col_w-1:0] col_cnt;
    logic in_sof;
    logic in_eol;

    // fifo storage and pointers with a wrap bit
    logic [fifo_entry_w-1:0] mem [fifo_depth];
    logic [fifo_aw:0] wr_ptr;
    logic [fifo_aw:0] rd_ptr;
    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;
    logic [fifo_entry_w-1:0] head;

    // tag the incoming pixel
    assign in_sof = sof_pend;
    assign in_eol = (col_cnt == last_col);

    // the sensor cannot stall so a pixel hitting a full fifo is lost
    assign wr_en = bus.lv && !full;
    assign rd_en = pix_valid && pix_ready;

    // same index with different wrap bits means full
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                  (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            fv_q <= 1'b0;
            sof_pend <= 1'b0;
            col_cnt <= '0;
        end else begin
            fv_q <= bus.fv;
            if (bus.fv && !fv_q) begin
                sof_pend <= 1'b1;
                col_cnt <= '0;
            end else if (bus.lv) begin
                // wraps back to zero after the last column
                sof_pend <= 1'b0;
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[fifo_aw-1:0]] <= {in_sof, in_eol, bus.d};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            overflow <= 1'b0;
            frame_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (bus.lv && full) begin
                overflow <= 1'b1;
            end
            // count on fv falling
            if (!bus.fv && fv_q) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // head entry holds steady until it is accepted
    assign head = mem[rd_ptr[fifo_aw-1:0]];
    assign pix_valid = !empty;
    assign {pix_sof, pix_eol, pix_data} = head;

endmodule

// File: logic/img_sensor_top.sv
`timescale 1ns/1ps

module img_sensor_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   enable,
    input  img_data_pkg::pattern_t                 pattern,
    output logic [img_data_pkg::pix_w-1:0]         pix_data,
    output logic                                   pix_sof,
    output logic                                   pix_eol,
    output logic                                   pix_valid,
    input  logic                                   pix_ready,
    output logic                                   overflow,
    output logic [img_data_pkg::frame_cnt_w-1:0]   frame_count
);
    import img_timing_pkg::*;

    // sensor bus shared by the emulator parts and capture
    img_bus_if bus ();

    // fsm to timer handshake
    logic load;
    logic [timer_w-1:0] load_value;
    logic done;

    // emulator side
    img_seq_fsm img_seq_fsm_i (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .bus        (bus.seq),
        .load       (load),
        .load_value (load_value),
        .done       (done)
    );

    img_gap_timer img_gap_timer_i (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .load_value (load_value),
        .done       (done)
    );

    img_pixel_gen img_pixel_gen_i (
        .clk     (clk),
        .reset   (reset),
        .pattern (pattern),
        .bus     (bus.gen)
    );

    // capture side
    img_capture img_capture_i (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus.cap),
        .pix_data    (pix_data),
        .pix_sof     (pix_sof),
        .pix_eol     (pix_eol),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .overflow    (overflow),
        .frame_count (frame_count)
    );

endmodule

// File: verif/img_sensor_tb.sv
`timescale 1ns/1ps

module img_sensor_tb;
    import img_timing_pkg::*;
    import img_data_pkg::*;

    // ready modes of the table
    localparam int mode_high = 0;
    localparam int mode_alt = 1;
    localparam int mode_rand = 2;
    localparam int mode_low = 3;

    localparam int num_rows = 6;
    localparam int frame_pixels = img_width * img_height;
    // blank, lead, lines with their gaps, trail
    localparam int frame_len = 2 * gap_cycles + img_height * (img_width + gap_cycles) + gap_cycles;
    localparam int cycle_limit = (num_rows + 1) * frame_len * 2;

    logic clk;
    logic reset;
    logic enable;
    pattern_t pattern;
    logic [pix_w-1:0] pix_data;
    logic pix_sof;
    logic pix_eol;
    logic pix_valid;
    logic pix_ready;
    logic overflow;
    logic [frame_cnt_w-1:0] frame_count;

    // test table with one frame per row
    pattern_t row_pat [num_rows];
    int row_mode [num_rows];
    logic row_ov [num_rows];

    // expected beats of the current frame
    logic [pix_w-1:0] exp_data [frame_pixels];
    logic exp_sof [frame_pixels];
    logic exp_eol [frame_pixels];
    int exp_n;
    int beat_idx;

    int errors;
    int cycles;
    int cur_mode;
    pattern_t cur_pat;
    logic hold_low;
    logic alt_phase;
    integer seed;

    img_sensor_top img_sensor_top_i (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .pattern     (pattern),
        .pix_data    (pix_data),
        .pix_sof     (pix_sof),
        .pix_eol     (pix_eol),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .overflow    (overflow),
        .frame_count (frame_count)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // pixel value from the pattern rules
    function automatic logic [pix_w-1:0] expected_pixel(input pattern_t pat,
                                                         input int row, input int col);
        int idx;
        logic [pix_w-1:0] px;
        idx = row * img_width + col;
        case (pat)
            pat_grid: px = ((row % 4) == 0 && (col % 4) == 0) ? {pix_w{1'b1}} : '0;
            pat_rowcol: px = {row[5:0], col[5:0]};
            // running count in raster order
            default: px = idx[pix_w-1:0];
        endcase
        return px;
    endfunction

    task automatic build_expected(input pattern_t pat, input int mode);
        int r;
        int c;
        int idx;
        // a stalled frame keeps only what fits in the fifo
        exp_n = (mode == mode_low) ? fifo_depth : frame_pixels;
        for (r = 0; r < img_height; r++) begin
            for (c = 0; c < img_width; c++) begin
                idx = r * img_width + c;
                exp_data[idx] = expected_pixel(pat, r, c);
                exp_sof[idx] = (idx == 0);
                exp_eol[idx] = (c == img_width - 1);
            end
        end
        beat_idx = 0;
    endtask

    task automatic take_beat();
        if (beat_idx < exp_n) begin
            check_value("pix_data", 32'(pix_data), 32'(exp_data[beat_idx]));
            check_value("pix_sof", 32'(pix_sof), 32'(exp_sof[beat_idx]));
            check_value("pix_eol", 32'(pix_eol), 32'(exp_eol[beat_idx]));
        end else begin
            $display("beat %0d arrived after the end of the expected stream", beat_idx);
            errors = errors + 1;
        end
        beat_idx = beat_idx + 1;
    endtask

    // drive on the rising edge and look at the stream on the falling edge
    task automatic run_cycle(input logic en);
        logic rdy;
        @(posedge clk);
        case (cur_mode)
            mode_alt: rdy = alt_phase;
            // high unless the low two bits are zero
            mode_rand: rdy = ($random(seed) & 3) != 0;
            mode_low: rdy = !hold_low;
            default: rdy = 1'b1;
        endcase
        alt_phase = !alt_phase;
        enable <= en;
        pix_ready <= rdy;
        pattern <= cur_pat;
        @(negedge clk);
        // transfer happens at the coming edge
        if (pix_valid && pix_ready) begin
            take_beat();
        end
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, the stream stopped making progress", cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int i;
        int row_errors;
        int tests_failed;
        logic [frame_cnt_w-1:0] fc_start;

        clk = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        pattern = pat_ramp;
        pix_ready = 1'b0;
        errors = 0;
        tests_failed = 0;
        cur_mode = mode_high;
        cur_pat = pat_ramp;
        hold_low = 1'b0;
        alt_phase = 1'b0;
        seed = 2269;
        exp_n = 0;
        beat_idx = 0;

        // pattern, ready mode, expected overflow
        row_pat[0] = pat_ramp;
        row_mode[0] = mode_high;
        row_ov[0] = 1'b0;
        row_pat[1] = pat_grid;
        row_mode[1] = mode_high;
        row_ov[1] = 1'b0;
        row_pat[2] = pat_rowcol;
        row_mode[2] = mode_high;
        row_ov[2] = 1'b0;
        row_pat[3] = pat_rowcol;
        row_mode[3] = mode_alt;
        row_ov[3] = 1'b0;
        row_pat[4] = pat_ramp;
        row_mode[4] = mode_rand;
        row_ov[4] = 1'b0;
        // stalled frame goes last since overflow is sticky
        row_pat[5] = pat_ramp;
        row_mode[5] = mode_low;
        row_ov[5] = 1'b1;

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // quiet outputs with enable low
        repeat (20) begin
            run_cycle(1'b0);
            check_value("pix_valid", 32'(pix_valid), 32'(0));
            check_value("overflow", 32'(overflow), 32'(0));
            check_value("frame_count", 32'(frame_count), 32'(0));
        end
        $display("test reset: %0d errors", errors);
        if (errors != 0) begin
            tests_failed = tests_failed + 1;
        end

        for (i = 0; i < num_rows; i++) begin
            row_errors = errors;
            cur_mode = row_mode[i];
            hold_low = (row_mode[i] == mode_low);
            build_expected(row_pat[i], row_mode[i]);
            fc_start = frame_count;
            cur_pat = row_pat[i];
            // one cycle of enable starts exactly one frame
            run_cycle(1'b1);
            while (frame_count == fc_start) begin
                run_cycle(1'b0);
            end
            // rest of the trail until the fsm is back in idle
            repeat (gap_cycles + 2) begin
                run_cycle(1'b0);
            end
            hold_low = 1'b0;
            while (pix_valid) begin
                run_cycle(1'b0);
            end
            if (beat_idx != exp_n) begin
                $display("frame %0d delivered %0d beats instead of %0d", i, beat_idx, exp_n);
                errors = errors + 1;
            end
            check_value("frame_count", 32'(frame_count), 32'(i + 1));
            check_value("overflow", 32'(overflow), 32'(row_ov[i]));
            row_errors = errors - row_errors;
            $display("test %0d %s ready mode %0d: %0d beats, %0d errors",
                     i, row_pat[i].name(), row_mode[i], beat_idx, row_errors);
            if (row_errors != 0) begin
                tests_failed = tests_failed + 1;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", num_rows + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
logic/img_timing_pkg.sv
logic/img_data_pkg.sv
logic/img_bus_if.sv
logic/img_seq_fsm.sv
logic/img_gap_timer.sv
logic/img_pixel_gen.sv
logic/img_capture.sv
logic/img_sensor_top.sv
verif/img_sensor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the image sensor testbench with verilator
set -u

cd "$(dirname "$0")"

top=img_sensor_tb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f src.f --top-module "$top" --Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/V$top" | tee "$log_file"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# result comes from the log, not the exit code
if grep -q "^TB PASSED$" "$log_file"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail, see $log_file"
    exit 1
fi
